// File: sim.f
rtl/iq_data_pkg.sv
rtl/iq_ptr_pkg.sv
rtl/iq_write_stage.sv
rtl/iq_storage.sv
rtl/iq_occupancy.sv
rtl/iq_read_stage.sv
rtl/iq_top.sv
verif/iq_props.sv
verif/tb_iq_top.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f sim.f --top-module tb_iq_top -o tb_iq_top
	./obj_dir/tb_iq_top | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_iq_top.sv
// Instruction queue testbench
`timescale 1ns/1ps
`default_nettype none

module tb_iq_top
  import iq_data_pkg::*;
  import iq_ptr_pkg::*;
();

  localparam int W_LANES      = 4;
  localparam int R_LANES      = 3;
  localparam int RESET_CYCLES = 4;
  localparam int N_RANDOM     = 400;
  localparam int FILL_CYCLES  = 6;
  localparam int DRAIN_CYCLES = 7;
  localparam int TEST_CYCLES  = RESET_CYCLES + N_RANDOM + FILL_CYCLES + DRAIN_CYCLES + 12;
  localparam int WATCHDOG_NS  = (TEST_CYCLES + 50) * 20;

  logic               clk = 1'b0;
  logic               rst;
  logic               flush;
  logic               write_wen;
  logic [W_LANES-1:0] write_instr_en;
  instr_t             write_instr [W_LANES];
  tag_t               write_tag [W_LANES];
  logic               fetch_stall;
  logic               read_clk_en;
  logic [R_LANES-1:0] read_instr_en;
  instr_t             read_instr [R_LANES];
  tag_t               read_tag [R_LANES];
  logic [R_LANES-1:0] read_avail;

  int     seed = 26;
  instr_t model_instr [$]; // Oldest entry at index 0.
  tag_t   model_tag [$];

  iq_top #(
    .W_LANES (W_LANES),
    .R_LANES (R_LANES)
  ) i_iq_top (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .write_wen      (write_wen),
    .write_instr_en (write_instr_en),
    .write_instr    (write_instr),
    .write_tag      (write_tag),
    .fetch_stall    (fetch_stall),
    .read_clk_en    (read_clk_en),
    .read_instr_en  (read_instr_en),
    .read_instr     (read_instr),
    .read_tag       (read_tag),
    .read_avail     (read_avail)
  );

  always #10 clk = ~clk;

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "Run stopped at first error.");
  endtask

  task automatic mismatch(input string msg);
    stop_with_error($sformatf("MISMATCH at %0t: %s", $time, msg));
  endtask

  task automatic pick(input int range, output int value);
    value = $unsigned($random(seed)) % range;
  endtask

  function automatic logic [W_LANES-1:0] write_mask(input int n);
    logic [W_LANES-1:0] m;
    m = '0;
    for (int i = 0; i < W_LANES; i++) begin
      if (i < n) m[i] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic [R_LANES-1:0] read_mask(input int n);
    logic [R_LANES-1:0] m;
    m = '0;
    for (int r = 0; r < R_LANES; r++) begin
      if (r < n) m[r] = 1'b1;
    end
    return m;
  endfunction

  // Mirror of the inputs presented at this edge.
  task automatic update_model();
    int  n_pop;
    bit  stalled;
    n_pop = 0;
    stalled = model_instr.size() > DEPTH - W_LANES;
    if (rst || flush) begin
      model_instr.delete();
      model_tag.delete();
    end else begin
      for (int r = 0; r < R_LANES; r++) begin
        if (read_clk_en && read_instr_en[r] && model_instr.size() > r) n_pop++;
      end
      repeat (n_pop) begin
        void'(model_instr.pop_front());
        void'(model_tag.pop_front());
      end
      if (write_wen && !stalled) begin
        for (int i = 0; i < W_LANES; i++) begin
          if (write_instr_en[i]) begin
            model_instr.push_back(write_instr[i]);
            model_tag.push_back(write_tag[i]);
          end
        end
      end
    end
  endtask

  task automatic check_outputs();
    int cnt;
    cnt = model_instr.size();
    assert (fetch_stall == (cnt > DEPTH - W_LANES))
      else mismatch($sformatf("fetch_stall %0b with %0d queued", fetch_stall, cnt));
    for (int r = 0; r < R_LANES; r++) begin
      assert (read_avail[r] == (cnt > r))
        else mismatch($sformatf("read_avail[%0d] %0b with %0d queued", r, read_avail[r], cnt));
      if (cnt > r) begin
        assert (read_instr[r] == model_instr[r])
          else mismatch($sformatf("lane %0d instr %h, expected %h",
                                  r, read_instr[r], model_instr[r]));
        assert (read_tag[r] == model_tag[r])
          else mismatch($sformatf("lane %0d tag %h, expected %h", r, read_tag[r], model_tag[r]));
      end
    end
  endtask

  task automatic drive_cycle(input bit wen, input int n_write, input bit rce, input int n_read,
                             input bit fl);
    @(posedge clk);
    update_model();
    write_wen      <= wen;
    write_instr_en <= write_mask(n_write);
    for (int i = 0; i < W_LANES; i++) begin
      write_instr[i] <= $random(seed);
      write_tag[i]   <= tag_t'($random(seed));
    end
    read_clk_en   <= rce;
    read_instr_en <= read_mask(n_read);
    flush         <= fl;
    @(negedge clk); // Outputs settled from the registered count.
    check_outputs();
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_with_error("Timeout: the test sequence did not finish in time");
  end

  initial begin
    int roll;
    int n_w;
    int n_r;
    bit wen;
    bit rce;
    rst            = 1'b1;
    flush          = 1'b0;
    write_wen      = 1'b0;
    write_instr_en = '0;
    read_clk_en    = 1'b0;
    read_instr_en  = '0;
    for (int i = 0; i < W_LANES; i++) begin
      write_instr[i] = '0;
      write_tag[i]   = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_outputs();

    // Random groups and pops, wrapping the pointers many times.
    for (int c = 0; c < N_RANDOM; c++) begin
      pick(4, roll);
      wen = roll != 0;
      pick(W_LANES + 1, n_w);
      pick(4, roll);
      rce = roll != 0;
      pick(R_LANES + 1, n_r);
      pick(32, roll);
      drive_cycle(wen, n_w, rce, n_r, roll == 0);
    end

    // Fill with the reader idle, then drain.
    drive_cycle(1'b0, 0, 1'b0, 0, 1'b1);
    drive_cycle(1'b0, 0, 1'b0, 0, 1'b0);
    repeat (FILL_CYCLES) drive_cycle(1'b1, W_LANES, 1'b0, 0, 1'b0);
    repeat (DRAIN_CYCLES) drive_cycle(1'b0, 0, 1'b1, R_LANES, 1'b0);

    // Flush against a write and a pop in the same cycle.
    repeat (3) drive_cycle(1'b1, 3, 1'b0, 0, 1'b0);
    drive_cycle(1'b1, W_LANES, 1'b1, R_LANES, 1'b1);
    drive_cycle(1'b0, 0, 1'b0, 0, 1'b0);
    drive_cycle(1'b1, 2, 1'b0, 0, 1'b0);
    drive_cycle(1'b0, 0, 1'b0, 0, 1'b0);
    drive_cycle(1'b0, 0, 1'b0, 0, 1'b0);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/iq_props.sv
// Instruction queue flow control properties
`timescale 1ns/1ps
`default_nettype none

module iq_props #(
  parameter int R_LANES = 3
) (
  input wire logic               clk,
  input wire logic               rst,
  input wire logic               flush,
  input wire logic               write_wen,
  input wire logic               fetch_stall,
  input wire logic               read_clk_en,
  input wire logic [R_LANES-1:0] read_instr_en,
  input wire logic [R_LANES-1:0] read_avail
);

  reset_clears: assert property (@(posedge clk)
    rst |=> (!fetch_stall && read_avail == '0))
    else $error("fetch_stall or read_avail set in the cycle after reset");

  flush_clears: assert property (@(posedge clk) disable iff (rst)
    flush |=> (!fetch_stall && read_avail == '0))
    else $error("queue not empty in the cycle after flush");

  // Pops are limited to available lanes, so an empty queue stays empty.
  empty_holds: assert property (@(posedge clk) disable iff (rst)
    (read_avail == '0 && !write_wen) |=> read_avail == '0)
    else $error("read_avail rose on an empty queue without a write");

  // Only a pop or a flush releases a stall.
  stall_holds: assert property (@(posedge clk) disable iff (rst)
    (fetch_stall && !flush && !(read_clk_en && |read_instr_en)) |=> fetch_stall)
    else $error("fetch_stall fell without a pop or a flush");

endmodule

bind iq_top iq_props #(
  .R_LANES (R_LANES)
) i_props (
  .clk           (clk),
  .rst           (rst),
  .flush         (flush),
  .write_wen     (write_wen),
  .fetch_stall   (fetch_stall),
  .read_clk_en   (read_clk_en),
  .read_instr_en (read_instr_en),
  .read_avail    (read_avail)
);

`default_nettype wire

// File: rtl/iq_top.sv
// Instruction queue top level
`timescale 1ns/1ps
`default_nettype none

module iq_top
  import iq_data_pkg::*;
  import iq_ptr_pkg::*;
#(
  parameter int W_LANES = 4,
  parameter int R_LANES = 3
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  input  logic               write_wen,
  input  logic [W_LANES-1:0] write_instr_en,
  input  instr_t             write_instr [W_LANES],
  input  tag_t               write_tag [W_LANES],
  output logic               fetch_stall,
  input  logic               read_clk_en,
  input  logic [R_LANES-1:0] read_instr_en,
  output instr_t             read_instr [R_LANES],
  output tag_t               read_tag [R_LANES],
  output logic [R_LANES-1:0] read_avail
);

  logic [W_LANES-1:0] slot_wen;
  ptr_t               slot_addr [W_LANES];
  instr_t             slot_instr [W_LANES];
  tag_t               slot_tag [W_LANES];
  ptr_t               rd_addr [R_LANES];
  count_t             write_num;
  count_t             read_num;

  iq_write_stage #(
    .W_LANES (W_LANES)
  ) i_write_stage (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .write_wen      (write_wen),
    .write_instr_en (write_instr_en),
    .write_instr    (write_instr),
    .write_tag      (write_tag),
    .fetch_stall    (fetch_stall),
    .slot_wen       (slot_wen),
    .slot_addr      (slot_addr),
    .slot_instr     (slot_instr),
    .slot_tag       (slot_tag),
    .write_num      (write_num)
  );

  iq_storage #(
    .W_LANES (W_LANES),
    .R_LANES (R_LANES)
  ) i_storage (
    .clk        (clk),
    .slot_wen   (slot_wen),
    .slot_addr  (slot_addr),
    .slot_instr (slot_instr),
    .slot_tag   (slot_tag),
    .rd_addr    (rd_addr),
    .read_instr (read_instr),
    .read_tag   (read_tag)
  );

  // Shared count between the two pointer stages.
  iq_occupancy #(
    .W_LANES (W_LANES),
    .R_LANES (R_LANES)
  ) i_occupancy (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .write_num   (write_num),
    .read_num    (read_num),
    .fetch_stall (fetch_stall),
    .read_avail  (read_avail)
  );

  iq_read_stage #(
    .R_LANES (R_LANES)
  ) i_read_stage (
    .clk           (clk),
    .rst           (rst),
    .flush         (flush),
    .read_clk_en   (read_clk_en),
    .read_instr_en (read_instr_en),
    .read_avail    (read_avail),
    .rd_addr       (rd_addr),
    .read_num      (read_num)
  );

endmodule

`default_nettype wire

// File: rtl/iq_read_stage.sv
// Instruction queue read stage
`timescale 1ns/1ps
`default_nettype none

module iq_read_stage
  import iq_ptr_pkg::*;
#(
  parameter int R_LANES = 3
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  input  logic               read_clk_en,
  input  logic [R_LANES-1:0] read_instr_en,
  input  logic [R_LANES-1:0] read_avail,
  output ptr_t               rd_addr [R_LANES],
  output count_t             read_num
);

  ptr_t               head;
  logic [R_LANES-1:0] pop_mask;
  count_t             pop_cnt;

  // Only lanes both requested and holding data leave the queue.
  assign pop_mask = read_instr_en & read_avail;

  always_comb begin
    pop_cnt = '0;
    for (int r = 0; r < R_LANES; r++) begin
      if (pop_mask[r]) begin
        pop_cnt = pop_cnt + count_t'(1);
      end
    end
  end

  assign read_num = (read_clk_en && !flush) ? pop_cnt : '0;

  // Lane r always shows the entry at head+r.
  for (genvar r = 0; r < R_LANES; r++) begin : g_addr
    assign rd_addr[r] = head + ptr_t'(r);
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head <= '0;
    end else begin
      head <= head + ptr_t'(read_num); // Zero when idle.
    end
  end

endmodule

`default_nettype wire

// File: rtl/iq_occupancy.sv
// Instruction queue occupancy counter
`timescale 1ns/1ps
`default_nettype none

module iq_occupancy
  import iq_ptr_pkg::*;
#(
  parameter int W_LANES = 4,
  parameter int R_LANES = 3
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  input  count_t             write_num,
  input  count_t             read_num,
  output logic               fetch_stall,
  output logic [R_LANES-1:0] read_avail
);

  count_t count;

  // Stall once a full write group would no longer fit.
  assign fetch_stall = count > count_t'(DEPTH - W_LANES);

  // Lane r holds a valid entry while more than r are queued.
  for (genvar r = 0; r < R_LANES; r++) begin : g_avail
    assign read_avail[r] = count > count_t'(r);
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      count <= '0;
    end else begin
      count <= count + write_num - read_num; // Net change this cycle.
    end
  end

endmodule

`default_nettype wire

// File: rtl/iq_storage.sv
// Instruction queue entry array
`timescale 1ns/1ps
`default_nettype none

module iq_storage
  import iq_data_pkg::*;
  import iq_ptr_pkg::*;
#(
  parameter int W_LANES = 4,
  parameter int R_LANES = 3
) (
  input  logic               clk,
  input  logic [W_LANES-1:0] slot_wen,
  input  ptr_t               slot_addr [W_LANES],
  input  instr_t             slot_instr [W_LANES],
  input  tag_t               slot_tag [W_LANES],
  input  ptr_t               rd_addr [R_LANES],
  output instr_t             read_instr [R_LANES],
  output tag_t               read_tag [R_LANES]
);

  instr_t instr_mem [DEPTH];
  tag_t   tag_mem [DEPTH];

  // Lane slots are consecutive, so no two lanes hit the same entry.
  always_ff @(posedge clk) begin
    for (int w = 0; w < W_LANES; w++) begin
      if (slot_wen[w]) begin
        instr_mem[slot_addr[w]] <= slot_instr[w];
        tag_mem[slot_addr[w]]   <= slot_tag[w];
      end
    end
  end

  for (genvar r = 0; r < R_LANES; r++) begin : g_rd
    assign read_instr[r] = instr_mem[rd_addr[r]]; // Combinational lookup.
    assign read_tag[r]   = tag_mem[rd_addr[r]];
  end

endmodule

`default_nettype wire

// File: rtl/iq_write_stage.sv
// Instruction queue write stage
`timescale 1ns/1ps
`default_nettype none

module iq_write_stage
  import iq_data_pkg::*;
  import iq_ptr_pkg::*;
#(
  parameter int W_LANES = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               flush,
  input  logic               write_wen,
  input  logic [W_LANES-1:0] write_instr_en,
  input  instr_t             write_instr [W_LANES],
  input  tag_t               write_tag [W_LANES],
  input  logic               fetch_stall,
  output logic [W_LANES-1:0] slot_wen,
  output ptr_t               slot_addr [W_LANES],
  output instr_t             slot_instr [W_LANES],
  output tag_t               slot_tag [W_LANES],
  output count_t             write_num
);

  logic   accept;
  ptr_t   wp;
  count_t lane_cnt;

  // Flush wins over an incoming group.
  assign accept = write_wen && !fetch_stall && !flush;

  // Thermometer mask, so the group size is the number of set bits.
  always_comb begin
    lane_cnt = '0;
    for (int i = 0; i < W_LANES; i++) begin
      if (write_instr_en[i]) begin
        lane_cnt = lane_cnt + count_t'(1);
      end
    end
  end

  // Lane i lands in slot wp+i.
  for (genvar i = 0; i < W_LANES; i++) begin : g_lane
    assign slot_wen[i]   = accept && write_instr_en[i];
    assign slot_addr[i]  = wp + ptr_t'(i); // Wraps at DEPTH.
    assign slot_instr[i] = write_instr[i];
    assign slot_tag[i]   = write_tag[i];
  end

  assign write_num = accept ? lane_cnt : '0;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wp <= '0;
    end else if (accept) begin
      wp <= wp + ptr_t'(lane_cnt);
    end
  end

endmodule

`default_nettype wire

// File: rtl/iq_ptr_pkg.sv
// Instruction queue pointer types
`default_nettype none

package iq_ptr_pkg;

  localparam int DEPTH = 16;
  localparam int PTR_W = 4;

  // Slot index, wraps modulo DEPTH.
  typedef logic [PTR_W-1:0] ptr_t;

  // Occupancy, 0 up to DEPTH inclusive.
  typedef logic [PTR_W:0] count_t;

endpackage

`default_nettype wire

// File: rtl/iq_data_pkg.sv
// Instruction queue payload types
`default_nettype none

package iq_data_pkg;

  localparam int INSTR_W = 32;
  localparam int TAG_W   = 8;

  // One fetched instruction word.
  typedef logic [INSTR_W-1:0] instr_t;

  // Predecode and fault bits riding with the instruction.
  typedef logic [TAG_W-1:0] tag_t;

endpackage

`default_nettype wire
